/* rtl/cpuPkg.sv */
`default_nettype none

package cpuPkg;

    localparam int DataWidth    = 32;
    localparam int IdWidth      = 7;
    localparam int RegAddrWidth = 4;
    localparam int ImmWidth     = 16;

    localparam logic [IdWidth-1:0] IdHalt = IdWidth'(75);

    typedef enum logic [3:0] {
        AluPassA   = 4'd0,
        AluAnd     = 4'd1,
        AluAdd     = 4'd2,
        AluAnd3    = 4'd3,
        AluBic     = 4'd4,  // A and not B
        AluSub     = 4'd5,
        AluXor     = 4'd6,
        AluAdd7    = 4'd7,
        AluOr      = 4'd8,
        AluSub9    = 4'd9,
        AluPassA10 = 4'd10,
        AluPassA11 = 4'd11,
        AluPassB   = 4'd12,
        AluXor13   = 4'd13,
        AluOr14    = 4'd14,
        AluPassB15 = 4'd15
    } aluOpE;

    // Codes 1 and 6 to 8 have no shift of their own
    typedef enum logic [3:0] {
        ShiftAlu  = 4'd0,
        ShiftRes1 = 4'd1,
        ShiftLsl  = 4'd2,
        ShiftLsr  = 4'd3,
        ShiftAsr  = 4'd4,
        ShiftRor  = 4'd5,
        ShiftRes6 = 4'd6,
        ShiftRes7 = 4'd7,
        ShiftRes8 = 4'd8
    } shiftOpE;

    typedef enum logic [2:0] {
        RbNone   = 3'd0,
        RbResult = 3'd1,
        RbLoad   = 3'd3,
        RbLink   = 3'd4,  // r14
        RbStack  = 3'd5,  // r13
        RbFlags  = 3'd6
    } rbModeE;

    typedef enum logic [2:0] {
        ExtNone     = 3'd0,
        ExtZeroByte = 3'd1,
        ExtSignByte = 3'd2,
        ExtZeroHalf = 3'd3,
        ExtSignHalf = 3'd4
    } extModeE;

    typedef enum logic [2:0] {
        SpecNone    = 3'd0,
        SpecNzShift = 3'd1,
        SpecNzcv    = 3'd2,
        SpecCompare = 3'd3,
        SpecLoad    = 3'd4,
        SpecMode    = 3'd5
    } specModeE;

    typedef enum logic [1:0] {
        StackNone = 2'd0,
        StackPush = 2'd1,
        StackPop  = 2'd2
    } stackOpE;

    typedef struct packed {
        aluOpE    aluOp;
        shiftOpE  shiftOp;
        rbModeE   rbMode;
        extModeE  bExt;
        extModeE  loadExt;
        specModeE specMode;
        stackOpE  stackOp;
        logic     memWrite;
        logic     useOffset;
        logic     isInput;
        logic     isOutput;
        logic     enable;
    } ctrlWordT;

    typedef struct packed {
        logic n;
        logic z;
        logic c;
        logic v;
    } flagsT;

    // Low half plus the bit that fills the upper part of the word
    typedef struct packed {
        logic                fill;
        logic [ImmWidth-1:0] low;
    } extT;

    function automatic extT extend(logic [ImmWidth-1:0] value, extModeE mode);
        extT r;
        r.fill = 1'b0;
        r.low  = value;
        case (mode)
            ExtZeroByte: r.low = {{(ImmWidth-8){1'b0}}, value[7:0]};
            ExtSignByte: begin
                r.fill = value[7];
                r.low  = {{(ImmWidth-8){value[7]}}, value[7:0]};
            end
            ExtSignHalf: r.fill = value[ImmWidth-1];
            default: r.fill = 1'b0;  // None and zero half keep the value
        endcase
        return r;
    endfunction

endpackage

`default_nettype wire

/* rtl/ControlCore.sv */
`timescale 1ns/1ns
`default_nettype none

module ControlCore (
    input  logic [cpuPkg::IdWidth-1:0] id,
    input  logic                       confirmation,
    input  logic                       continueButton,
    input  logic                       modeFlag,
    output cpuPkg::ctrlWordT           ctrl
);
    import cpuPkg::*;

    always_comb begin
        ctrl.aluOp    = AluPassB;
        ctrl.shiftOp  = ShiftAlu;
        ctrl.rbMode   = RbResult;
        ctrl.bExt     = ExtNone;
        ctrl.loadExt  = ExtNone;
        ctrl.specMode = SpecNone;
        ctrl.stackOp  = StackNone;
        ctrl.enable   = 1'b1;

        ctrl.useOffset = id inside {[1:3], [6:11], 39, [48:57], [59:62], 72, 73};
        ctrl.memWrite  = id inside {[40:42], 48, 50, 52, 54, 67};
        ctrl.isOutput  = (id == 69);
        ctrl.isInput   = (id == 71);

        case (id) inside
            4, 6, 10, 23, [28:30], 38, [39:57], 73: ctrl.aluOp = AluAdd;
            5, 7, 9, 11, 22, [31:33]:              ctrl.aluOp = AluSub;
            12: ctrl.aluOp = AluAnd3;
            13: ctrl.aluOp = AluXor13;
            17: ctrl.aluOp = AluAnd;
            18: ctrl.aluOp = AluOr;
            20: ctrl.aluOp = AluOr14;
            21: ctrl.aluOp = AluXor;
            24: ctrl.aluOp = AluAdd7;
            25: ctrl.aluOp = AluSub9;
            26: ctrl.aluOp = AluBic;
            34: ctrl.aluOp = AluPassA10;
            65: ctrl.aluOp = AluPassA11;
            69, 71: ctrl.aluOp = AluPassA;
            76: ctrl.aluOp = AluPassB15;  // PXR
            default: ctrl.aluOp = AluPassB;
        endcase

        case (id) inside
            1, 14: ctrl.shiftOp = ShiftLsr;
            2, 15: ctrl.shiftOp = ShiftAsr;
            3, 16: ctrl.shiftOp = ShiftLsl;
            19:    ctrl.shiftOp = ShiftRor;
            39:    ctrl.shiftOp = ShiftRes1;
            63:    ctrl.shiftOp = ShiftRes6;
            64:    ctrl.shiftOp = ShiftRes7;
            66:    ctrl.shiftOp = ShiftRes8;
            default: ctrl.shiftOp = ShiftAlu;
        endcase

        case (id) inside
            [1:3], [14:16], 19:                              ctrl.specMode = SpecNzShift;
            [4:7], [9:11], 17, 18, [21:23], [31:33], 76:     ctrl.specMode = SpecNzcv;
            8, 12, 13, 20, [24:27]:                          ctrl.specMode = SpecCompare;
            34, 65:                                          ctrl.specMode = SpecLoad;
            72:                                              ctrl.specMode = SpecMode;
            default: ctrl.specMode = SpecNone;
        endcase

        case (id) inside
            9, 22, 23, 30, 32, 33, 38, [40:42], 48, 50, 52, 54, 67,
            69, 70, [73:75], 77:                             ctrl.rbMode = RbNone;
            39, [43:47], 49, 51, 53, 55, 68, 71:             ctrl.rbMode = RbLoad;
            58:      ctrl.rbMode = RbFlags;                  // CXPR
            72:      ctrl.rbMode = modeFlag ? RbStack : RbLink;  // SWI
            [1:77]:  ctrl.rbMode = RbResult;
            default: ctrl.rbMode = RbNone;                   // Unknown id
        endcase

        case (id) inside
            54, 55, 60, 73: ctrl.bExt = ExtSignByte;
            59:             ctrl.bExt = ExtZeroByte;
            61:             ctrl.bExt = ExtZeroHalf;
            62:             ctrl.bExt = ExtSignHalf;
            default:        ctrl.bExt = ExtNone;
        endcase

        case (id) inside
            43:      ctrl.loadExt = ExtSignByte;
            45, 53:  ctrl.loadExt = ExtZeroHalf;
            46, 51:  ctrl.loadExt = ExtSignHalf;
            47:      ctrl.loadExt = ExtZeroByte;
            default: ctrl.loadExt = ExtNone;
        endcase

        case (id) inside
            67:      ctrl.stackOp = StackPush;
            68:      ctrl.stackOp = StackPop;
            default: ctrl.stackOp = StackNone;
        endcase

        case (id) inside
            69, 71:  ctrl.enable = confirmation;    // OUTPUT, INPUT
            70:      ctrl.enable = continueButton;  // PAUSE
            default: ctrl.enable = 1'b1;
        endcase
    end

endmodule

`default_nettype wire

/* rtl/ShiftUnit.sv */
`timescale 1ns/1ns
`default_nettype none

module ShiftUnit #(
    parameter int DataWidth = cpuPkg::DataWidth
) (
    input  logic [DataWidth-1:0]        a,
    input  logic [DataWidth-1:0]        rmValue,
    input  logic [cpuPkg::ImmWidth-1:0] imm,
    input  cpuPkg::ctrlWordT            ctrl,
    output logic [DataWidth-1:0]        b,
    output logic [DataWidth-1:0]        shiftResult,
    output logic                        shiftCarry
);
    import cpuPkg::*;

    localparam int AmtWidth = $clog2(DataWidth);

    extT                 immParts;
    logic [AmtWidth-1:0] amt;
    logic [DataWidth:0]  lslWide;
    logic [DataWidth:0]  lsrWide;
    logic [DataWidth:0]  asrWide;
    logic [DataWidth-1:0] rorValue;

    assign immParts = extend(imm, ctrl.bExt);
    assign b        = ctrl.useOffset ? {{(DataWidth-ImmWidth){immParts.fill}}, immParts.low}
                                     : rmValue;
    assign amt      = b[AmtWidth-1:0];

    // Extra bit catches the last bit shifted out
    assign lslWide  = {1'b0, a} << amt;
    assign lsrWide  = {a, 1'b0} >> amt;
    assign asrWide  = $signed({a, 1'b0}) >>> amt;
    assign rorValue = (a >> amt) | (a << (DataWidth - int'(amt)));

    always_comb begin
        shiftResult = a;
        shiftCarry  = 1'b0;
        case (ctrl.shiftOp)
            ShiftLsl: {shiftCarry, shiftResult} = lslWide;
            ShiftLsr: {shiftResult, shiftCarry} = lsrWide;
            ShiftAsr: {shiftResult, shiftCarry} = asrWide;
            ShiftRor: begin
                shiftResult = rorValue;
                shiftCarry  = (amt != '0) && rorValue[DataWidth-1];
            end
            default: shiftCarry = 1'b0;  // Result comes from the ALU
        endcase
    end

endmodule

`default_nettype wire

/* rtl/Alu.sv */
`timescale 1ns/1ns
`default_nettype none

module Alu #(
    parameter int DataWidth = cpuPkg::DataWidth
) (
    input  logic [DataWidth-1:0] a,
    input  logic [DataWidth-1:0] b,
    input  cpuPkg::aluOpE        aluOp,
    output logic [DataWidth-1:0] result,
    output cpuPkg::flagsT        flags
);
    import cpuPkg::*;

    logic [DataWidth:0] sum;
    logic [DataWidth:0] diff;
    logic               carry;
    logic               overflow;

    assign sum  = {1'b0, a} + {1'b0, b};
    assign diff = {1'b0, a} + {1'b0, ~b} + 1'b1;  // Carry set means no borrow

    always_comb begin
        result   = b;
        carry    = 1'b0;
        overflow = 1'b0;
        case (aluOp)
            AluPassA, AluPassA10, AluPassA11: result = a;
            AluAnd, AluAnd3: result = a & b;
            AluBic:          result = a & ~b;
            AluXor, AluXor13: result = a ^ b;
            AluOr, AluOr14:  result = a | b;
            AluAdd, AluAdd7: begin
                result   = sum[DataWidth-1:0];
                carry    = sum[DataWidth];
                overflow = (a[DataWidth-1] == b[DataWidth-1])
                           && (result[DataWidth-1] != a[DataWidth-1]);
            end
            AluSub, AluSub9: begin
                result   = diff[DataWidth-1:0];
                carry    = diff[DataWidth];
                overflow = (a[DataWidth-1] != b[DataWidth-1])
                           && (result[DataWidth-1] != a[DataWidth-1]);
            end
            default: result = b;  // Pass B
        endcase
    end

    always_comb begin
        flags.n = result[DataWidth-1];
        flags.z = (result == '0);
        flags.c = carry;
        flags.v = overflow;
    end

endmodule

`default_nettype wire

/* rtl/RegisterBank.sv */
`timescale 1ns/1ns
`default_nettype none

module RegisterBank #(
    parameter int DataWidth = cpuPkg::DataWidth
) (
    input  logic                            clk,
    input  logic                            arstN,
    input  logic                            commit,
    input  logic [cpuPkg::RegAddrWidth-1:0] rd,
    input  logic [cpuPkg::RegAddrWidth-1:0] rn,
    input  logic [cpuPkg::RegAddrWidth-1:0] rm,
    input  cpuPkg::ctrlWordT                ctrl,
    input  logic [DataWidth-1:0]            aluResult,
    input  logic [DataWidth-1:0]            shiftResult,
    input  logic [DataWidth-1:0]            memRdata,
    input  logic [DataWidth-1:0]            inData,
    input  logic [DataWidth-1:0]            flagWord,
    output logic [DataWidth-1:0]            a,
    output logic [DataWidth-1:0]            rdValue,
    output logic [DataWidth-1:0]            rmValue,
    output logic [DataWidth-1:0]            result,
    output logic [DataWidth-1:0]            stackAddr
);
    import cpuPkg::*;

    localparam int NumRegs = 2 ** RegAddrWidth;
    localparam logic [RegAddrWidth-1:0] StackReg = RegAddrWidth'(13);
    localparam logic [RegAddrWidth-1:0] LinkReg  = RegAddrWidth'(14);

    logic [DataWidth-1:0]    regs [NumRegs];
    extT                     loadParts;
    logic [DataWidth-1:0]    loadValue;
    logic                    wrEn;
    logic [RegAddrWidth-1:0] wrAddr;
    logic [DataWidth-1:0]    wrData;

    assign a       = regs[rn];
    assign rdValue = regs[rd];
    assign rmValue = regs[rm];

    assign result = (ctrl.shiftOp inside {ShiftLsl, ShiftLsr, ShiftAsr, ShiftRor})
                    ? shiftResult : aluResult;

    assign stackAddr = (ctrl.stackOp == StackPop) ? regs[StackReg]
                                                  : regs[StackReg] - DataWidth'(4);

    assign loadParts = extend(memRdata[ImmWidth-1:0], ctrl.loadExt);
    always_comb begin
        if (ctrl.isInput)
            loadValue = inData;  // Port word goes in unchanged
        else if (ctrl.loadExt == ExtNone)
            loadValue = memRdata;
        else
            loadValue = {{(DataWidth-ImmWidth){loadParts.fill}}, loadParts.low};
    end

    always_comb begin
        wrEn   = 1'b1;
        wrAddr = rd;
        wrData = result;
        case (ctrl.rbMode)
            RbResult: wrData = result;
            RbLoad:   wrData = loadValue;
            RbLink:   wrAddr = LinkReg;
            RbStack:  wrAddr = StackReg;
            RbFlags:  wrData = flagWord;
            default:  wrEn   = 1'b0;
        endcase
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            regs <= '{default: '0};
        end else if (commit) begin
            if (wrEn)
                regs[wrAddr] <= wrData;
            // Stack pointer step wins over a write to r13
            if (ctrl.stackOp == StackPush)
                regs[StackReg] <= regs[StackReg] - DataWidth'(4);
            else if (ctrl.stackOp == StackPop)
                regs[StackReg] <= regs[StackReg] + DataWidth'(4);
        end
    end

endmodule

`default_nettype wire

/* rtl/StatusRegister.sv */
`timescale 1ns/1ns
`default_nettype none

module StatusRegister #(
    parameter int DataWidth = cpuPkg::DataWidth
) (
    input  logic                 clk,
    input  logic                 arstN,
    input  logic                 commit,
    input  cpuPkg::ctrlWordT     ctrl,
    input  logic [DataWidth-1:0] result,
    input  cpuPkg::flagsT        aluFlags,
    input  logic                 shiftCarry,
    output cpuPkg::flagsT        flags,
    output logic                 modeFlag
);
    import cpuPkg::*;

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            flags    <= '0;
            modeFlag <= 1'b0;
        end else if (commit) begin
            case (ctrl.specMode)
                SpecNzShift: begin
                    flags.n <= result[DataWidth-1];
                    flags.z <= (result == '0);
                    flags.c <= shiftCarry;  // V kept
                end
                SpecNzcv, SpecCompare: flags <= aluFlags;
                SpecLoad: flags <= result[DataWidth-1 -: 4];  // NZCV from top nibble
                SpecMode: modeFlag <= 1'b1;
                default:  flags <= flags;
            endcase
        end
    end

endmodule

`default_nettype wire

/* rtl/ExecuteCore.sv */
`timescale 1ns/1ns
`default_nettype none

module ExecuteCore #(
    parameter int DataWidth = cpuPkg::DataWidth
) (
    input  logic                            clk,
    input  logic                            arstN,
    input  logic                            instrValid,
    input  logic [cpuPkg::IdWidth-1:0]      id,
    input  logic [cpuPkg::RegAddrWidth-1:0] rd,
    input  logic [cpuPkg::RegAddrWidth-1:0] rn,
    input  logic [cpuPkg::RegAddrWidth-1:0] rm,
    input  logic [cpuPkg::ImmWidth-1:0]     imm,
    input  logic [DataWidth-1:0]            memRdata,
    input  logic [DataWidth-1:0]            inData,
    input  logic                            confirmation,
    input  logic                            continueButton,
    output logic                            memWrite,
    output logic [DataWidth-1:0]            memAddr,
    output logic [DataWidth-1:0]            memWdata,
    output logic [DataWidth-1:0]            outData,
    output logic                            outStrobe,
    output logic                            stall,
    output logic                            halted
);
    import cpuPkg::*;

    ctrlWordT             ctrl;
    flagsT                aluFlags;
    flagsT                flags;
    logic                 modeFlag;
    logic                 commit;
    logic [DataWidth-1:0] a;
    logic [DataWidth-1:0] b;
    logic [DataWidth-1:0] rmValue;
    logic [DataWidth-1:0] rdValue;
    logic [DataWidth-1:0] aluResult;
    logic [DataWidth-1:0] shiftResult;
    logic                 shiftCarry;
    logic [DataWidth-1:0] result;
    logic [DataWidth-1:0] stackAddr;
    logic [DataWidth-1:0] flagWord;

    assign commit    = instrValid && ctrl.enable && !halted;
    assign stall     = instrValid && !ctrl.enable;
    assign memWrite  = commit && ctrl.memWrite;
    assign outStrobe = commit && ctrl.isOutput;
    assign memAddr   = (ctrl.stackOp == StackNone) ? aluResult : stackAddr;
    assign memWdata  = rdValue;
    assign outData   = a;
    assign flagWord  = {flags, {(DataWidth-5){1'b0}}, modeFlag};  // NZCV high, mode in bit 0

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN)
            halted <= 1'b0;
        else if (instrValid && id == IdHalt)
            halted <= 1'b1;  // Sticky until reset
    end

    ControlCore ControlCore_inst (
        .id             (id),
        .confirmation   (confirmation),
        .continueButton (continueButton),
        .modeFlag       (modeFlag),
        .ctrl           (ctrl)
    );

    ShiftUnit #(.DataWidth(DataWidth)) ShiftUnit_inst (
        .a           (a),
        .rmValue     (rmValue),
        .imm         (imm),
        .ctrl        (ctrl),
        .b           (b),
        .shiftResult (shiftResult),
        .shiftCarry  (shiftCarry)
    );

    Alu #(.DataWidth(DataWidth)) Alu_inst (
        .a      (a),
        .b      (b),
        .aluOp  (ctrl.aluOp),
        .result (aluResult),
        .flags  (aluFlags)
    );

    RegisterBank #(.DataWidth(DataWidth)) RegisterBank_inst (
        .clk         (clk),
        .arstN       (arstN),
        .commit      (commit),
        .rd          (rd),
        .rn          (rn),
        .rm          (rm),
        .ctrl        (ctrl),
        .aluResult   (aluResult),
        .shiftResult (shiftResult),
        .memRdata    (memRdata),
        .inData      (inData),
        .flagWord    (flagWord),
        .a           (a),
        .rdValue     (rdValue),
        .rmValue     (rmValue),
        .result      (result),
        .stackAddr   (stackAddr)
    );

    StatusRegister #(.DataWidth(DataWidth)) StatusRegister_inst (
        .clk        (clk),
        .arstN      (arstN),
        .commit     (commit),
        .ctrl       (ctrl),
        .result     (result),
        .aluFlags   (aluFlags),
        .shiftCarry (shiftCarry),
        .flags      (flags),
        .modeFlag   (modeFlag)
    );

endmodule

`default_nettype wire

/* sim/ExecuteCore_properties.sv */
`timescale 1ns/1ns
`default_nettype none

module ExecuteCore_properties (
    input wire logic clk,
    input wire logic arstN,
    input wire logic instrValid,
    input wire logic memWrite,
    input wire logic outStrobe,
    input wire logic stall,
    input wire logic halted
);

    // No side effects during a stall
    noStrobeInStall: assert property (@(posedge clk) disable iff (!arstN)
        stall |-> (!memWrite && !outStrobe))
        else $error("memWrite or outStrobe high while stalled");

    haltedSticky: assert property (@(posedge clk) disable iff (!arstN)
        halted |=> halted)
        else $error("halted fell without reset");

    stallNeedsValid: assert property (@(posedge clk) disable iff (!arstN)
        stall |-> instrValid)
        else $error("stall high without instrValid");

endmodule

`default_nettype wire

/* sim/ExecuteCoreTb.sv */
`timescale 1ns/1ns
`default_nettype none

module ExecuteCoreTb;
    logic        clk = 1'b0;
    logic        arstN;
    logic        instrValid;
    logic [6:0]  id;
    logic [3:0]  rd;
    logic [3:0]  rn;
    logic [3:0]  rm;
    logic [15:0] imm;
    logic [31:0] memRdata;
    logic [31:0] inData;
    logic        confirmation;
    logic        continueButton;
    wire logic        memWrite;
    wire logic [31:0] memAddr;
    wire logic [31:0] memWdata;
    wire logic [31:0] outData;
    wire logic        outStrobe;
    wire logic        stall;
    wire logic        halted;

    logic [31:0] mRegs [16];
    logic [3:0]  mFlags;  // n z c v
    logic        mMode;
    int          errors = 0;
    int          timeouts = 0;
    int          seed = 24;
    logic [6:0]  aluOps [13] = '{4, 5, 17, 18, 21, 14, 15, 16, 19, 59, 60, 61, 62};
    logic [6:0]  memOps [7] = '{40, 54, 43, 45, 46, 47, 55};

    always #4 clk = ~clk;

    ExecuteCore #(.DataWidth(32)) ExecuteCore_inst (.*);

    bind ExecuteCore ExecuteCore_properties ExecuteCore_properties_inst (
        .clk(clk), .arstN(arstN), .instrValid(instrValid), .memWrite(memWrite),
        .outStrobe(outStrobe), .stall(stall), .halted(halted)
    );

    task automatic checkValue(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
        if (got !== exp) begin
            $display("ERROR %s got 0x%08h expected 0x%08h", name, got, exp);
            errors++;
        end
    endtask

    function automatic logic [31:0] extendVal(input logic [31:0] v, input int mode);
        case (mode)
            1: return {24'h0, v[7:0]};
            2: return {{24{v[7]}}, v[7:0]};
            3: return {16'h0, v[15:0]};
            4: return {{16{v[15]}}, v[15:0]};
            default: return v;
        endcase
    endfunction

    function automatic int immMode(input logic [6:0] opId);
        case (opId)
            54, 55, 60: return 2;
            59: return 1;
            61: return 3;
            62: return 4;
            default: return 0;
        endcase
    endfunction

    // One committed instruction, outputs checked mid-cycle, model updated
    task automatic execute(input logic [6:0] opId, input logic [3:0] d, input logic [3:0] n,
                           input logic [3:0] m, input logic [15:0] im,
                           input logic [31:0] rdata);
        logic [31:0] opA;
        logic [31:0] opB;
        logic [31:0] res;
        logic [31:0] expAddr;
        logic [32:0] wide;
        logic [32:0] sWide;
        logic        carryOut;
        logic [3:0]  target;
        logic        wrEn;
        logic        expWrite;
        int          amt;
        opA = mRegs[n];
        opB = (opId inside {54, 55, [59:62], 72}) ? extendVal({16'h0, im}, immMode(opId))
                                                 : mRegs[m];
        amt = opB[4:0];
        res = 32'h0;
        wrEn = 1'b1;
        expWrite = 1'b0;
        expAddr = opA + opB;
        target = d;
        case (opId)
            4, 5: begin
                if (opId == 4) begin
                    wide = {1'b0, opA} + {1'b0, opB};
                    sWide = {opA[31], opA} + {opB[31], opB};
                    carryOut = wide[32];
                end else begin
                    wide = {1'b0, opA} - {1'b0, opB};
                    sWide = {opA[31], opA} - {opB[31], opB};
                    carryOut = (opA >= opB);  // No borrow
                end
                res = wide[31:0];
                mFlags = {res[31], res == 0, carryOut, sWide[32] != sWide[31]};
            end
            17, 18, 21: begin
                res = (opId == 17) ? opA & opB : (opId == 18) ? opA | opB : opA ^ opB;
                mFlags = {res[31], res == 0, 2'b00};
            end
            14, 15, 16, 19: begin
                case (opId)
                    16: begin
                        res = opA << amt;
                        mFlags[1] = (amt != 0) && opA[32-amt];
                    end
                    14: begin
                        res = opA >> amt;
                        mFlags[1] = (amt != 0) && opA[amt-1];
                    end
                    15: begin
                        res = $signed(opA) >>> amt;
                        mFlags[1] = (amt != 0) && opA[amt-1];
                    end
                    default: begin
                        res = opA;
                        mFlags[1] = 1'b0;
                        for (int k = 0; k < amt; k++) begin
                            mFlags[1] = res[0];  // Last bit rotated out
                            res = {res[0], res[31:1]};
                        end
                    end
                endcase
                mFlags[3] = res[31];  // V left alone
                mFlags[2] = (res == 0);
            end
            59, 60, 61, 62: res = opB;
            40, 54: begin
                wrEn = 1'b0;
                expWrite = 1'b1;
            end
            43, 45, 46, 47, 55: begin
                case (opId)
                    43: res = extendVal(rdata, 2);
                    45: res = extendVal(rdata, 3);
                    46: res = extendVal(rdata, 4);
                    47: res = extendVal(rdata, 1);
                    default: res = rdata;
                endcase
            end
            67: begin
                wrEn = 1'b0;
                expWrite = 1'b1;
                expAddr = mRegs[13] - 4;
            end
            68: begin
                res = rdata;
                expAddr = mRegs[13];
            end
            58: res = {mFlags, 27'h0, mMode};
            72: begin
                res = opB;
                target = mMode ? 4'd13 : 4'd14;
            end
            default: wrEn = 1'b0;  // OUTPUT
        endcase
        @(posedge clk);
        instrValid <= 1'b1;
        id <= opId;
        rd <= d;
        rn <= n;
        rm <= m;
        imm <= im;
        memRdata <= rdata;
        confirmation <= 1'b1;
        continueButton <= 1'b1;
        @(negedge clk);
        checkValue("stall", stall, 1'b0);
        checkValue("memWrite", memWrite, expWrite);
        checkValue("outStrobe", outStrobe, opId == 69);
        if (expWrite) begin
            checkValue("memWdata", memWdata, mRegs[d]);
        end
        if (expWrite || opId inside {43, 45, 46, 47, 55, 68}) begin
            checkValue("memAddr", memAddr, expAddr);
        end
        if (opId == 69) begin
            checkValue("outData", outData, mRegs[n]);
        end
        if (wrEn) begin
            mRegs[target] = res;
        end
        if (opId == 67) mRegs[13] = mRegs[13] - 4;
        if (opId == 68) mRegs[13] = mRegs[13] + 4;
        if (opId == 72) mMode = 1'b1;
    endtask

    task automatic showReg(input logic [3:0] r);
        execute(69, 0, r, 0, 0, 0);
    endtask

    task automatic stallCheck(input logic [6:0] opId, input logic [3:0] d, input logic [3:0] n,
                              input logic [31:0] portWord);
        int waitCount;
        @(posedge clk);
        instrValid <= 1'b1;
        id <= opId;
        rd <= d;
        rn <= n;
        inData <= portWord;
        confirmation <= 1'b0;
        continueButton <= 1'b0;
        repeat (3) begin
            @(negedge clk);
            checkValue("stall", stall, 1'b1);
            checkValue("outStrobe", outStrobe, 1'b0);
        end
        @(posedge clk);
        if (opId == 70) continueButton <= 1'b1;
        else confirmation <= 1'b1;
        @(negedge clk);
        waitCount = 0;
        while (stall && waitCount < 10) begin
            @(negedge clk);
            waitCount++;
        end
        if (stall) begin
            $display("Timeout: stall was not released for id %0d", opId);
            timeouts++;
        end else begin
            checkValue("outStrobe", outStrobe, opId == 69);
            if (opId == 69) checkValue("outData", outData, mRegs[n]);
            if (opId == 71) mRegs[d] = portWord;
        end
        @(posedge clk);
        instrValid <= 1'b0;
    endtask

    initial begin
        logic [6:0]  opId;
        logic [3:0]  d;
        logic [31:0] stackStart;
        int          waitCount;
        arstN <= 1'b0;
        instrValid <= 1'b0;
        id <= '0;
        rd <= '0;
        rn <= '0;
        rm <= '0;
        imm <= '0;
        memRdata <= '0;
        inData <= '0;
        confirmation <= 1'b0;
        continueButton <= 1'b0;
        mRegs = '{default: '0};
        mFlags = '0;
        mMode = 1'b0;
        repeat (4) @(posedge clk);
        arstN <= 1'b1;

        for (int i = 0; i < 60; i++) begin
            opId = aluOps[{$random(seed)} % 13];
            d = {$random(seed)} % 13;
            execute(opId, d, $random(seed), $random(seed), $random(seed), 0);
            showReg(d);
            if (i % 10 == 9) begin
                execute(58, 12, 0, 0, 0, 0);  // CXPR
                showReg(12);
            end
        end

        for (int i = 0; i < 24; i++) begin
            opId = memOps[{$random(seed)} % 7];
            d = {$random(seed)} % 13;
            execute(opId, d, $random(seed), $random(seed), $random(seed), $random(seed));
            showReg(d);
        end

        stackStart = mRegs[13];
        execute(67, 3, 0, 0, 0, 0);
        execute(68, 5, 0, 0, 0, $random(seed));
        @(posedge clk);
        id <= 7'd69;
        rn <= 4'd13;
        @(negedge clk);
        checkValue("r13", outData, stackStart);
        showReg(5);

        stallCheck(69, 0, 5, 0);
        stallCheck(71, 6, 0, $random(seed));
        showReg(6);
        stallCheck(70, 0, 0, 0);

        execute(72, 0, 0, 0, $random(seed), 0);
        showReg(14);
        execute(72, 0, 0, 0, $random(seed), 0);
        showReg(13);

        @(posedge clk);
        instrValid <= 1'b1;
        id <= 7'd75;
        waitCount = 0;
        @(negedge clk);
        while (!halted && waitCount < 10) begin
            @(negedge clk);
            waitCount++;
        end
        if (!halted) begin
            $display("Timeout: halted did not rise after HALT");
            timeouts++;
        end
        @(posedge clk);
        instrValid <= 1'b0;
        // Nothing commits now, so the model stays as it is
        for (int i = 0; i < 8; i++) begin
            @(posedge clk);
            instrValid <= 1'b1;
            id <= aluOps[{$random(seed)} % 13];
            rd <= $random(seed);
            rn <= $random(seed);
            rm <= $random(seed);
            imm <= $random(seed);
        end
        for (int r = 0; r < 16; r++) begin
            @(posedge clk);
            id <= 7'd69;
            rn <= r;
            @(negedge clk);
            checkValue("outData", outData, mRegs[r]);
            checkValue("outStrobe", outStrobe, 1'b0);
        end

        @(posedge clk);
        instrValid <= 1'b0;
        arstN <= 1'b0;
        repeat (4) @(posedge clk);
        arstN <= 1'b1;
        mRegs = '{default: '0};
        mFlags = '0;
        mMode = 1'b0;
        @(negedge clk);
        checkValue("halted", halted, 1'b0);
        for (int r = 0; r < 16; r++) showReg(r);
        execute(58, 1, 0, 0, 0, 0);
        showReg(1);

        @(posedge clk);
        instrValid <= 1'b0;
        @(posedge clk);
        $display("Errors: %0d, timeouts: %0d", errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

    initial begin
        #2000000;
        $display("Simulation ran out of time before the test sequence ended");
        $display("TESTBENCH FAILED");
        $finish;
    end

endmodule

`default_nettype wire

/* all.f */
rtl/cpuPkg.sv
rtl/ControlCore.sv
rtl/ShiftUnit.sv
rtl/Alu.sv
rtl/RegisterBank.sv
rtl/StatusRegister.sv
rtl/ExecuteCore.sv
sim/ExecuteCore_properties.sv
sim/ExecuteCoreTb.sv
